// ==== router.f ====
source/noc_params.sv
source/input_port.sv
source/vc_allocator.sv
source/switch_stage.sv
source/router.sv
tests/router_checker.sv
tests/router_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = router_tb
RTL_TOP  = router
FILELIST = router.f
OBJ_DIR  = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/router_tb.sv ====
`default_nettype none

module router_tb;

    timeunit 1ns;
    timeprecision 1ns;

    import noc_params::*;

    localparam int PACKETS = 200;
    localparam int MAX_LEN = 5;
    localparam int DS_DEPTH = 8;
    localparam int CYCLE_LIMIT = PACKETS * 40;

    logic                            clk = 1'b0;
    logic                            rst_n = 1'b0;
    link_t [PORT_NUM-1:0]            in_link = '0;
    logic [PORT_NUM-1:0][VC_NUM-1:0] in_on_off;
    logic [PORT_NUM-1:0][VC_NUM-1:0] in_vc_free;
    link_t [PORT_NUM-1:0]            out_link;
    logic [PORT_NUM-1:0][VC_NUM-1:0] out_on_off = '1;
    logic [PORT_NUM-1:0][VC_NUM-1:0] out_vc_free = '1;

    flit_t       exp_flit [PACKETS][MAX_LEN];
    int          exp_len [PACKETS];
    port_e       exp_port [PACKETS];
    int          sent = 0;
    logic [3:0]  ds_cnt [PORT_NUM][VC_NUM];     // downstream buffer fill.
    logic        ds_open [PORT_NUM][VC_NUM];
    int          pk_id [PORT_NUM][VC_NUM];
    int          pk_pos [PORT_NUM][VC_NUM];
    logic [31:0] rng = 32'hf706_1e61;
    int          errors;
    int          received;
    int          idle_errors = 0;

    router #(.BUFFER_SIZE(8), .X_CURRENT(1), .Y_CURRENT(1)) i_router (
        .clk(clk), .rst_n(rst_n), .in_link(in_link), .in_on_off(in_on_off),
        .in_vc_free(in_vc_free), .out_link(out_link), .out_on_off(out_on_off),
        .out_vc_free(out_vc_free)
    );

    router_checker #(.PACKETS(PACKETS), .MAX_LEN(MAX_LEN), .DS_DEPTH(DS_DEPTH)) i_checker (
        .clk(clk), .rst_n(rst_n), .out_link(out_link), .ds_cnt(ds_cnt), .ds_open(ds_open),
        .exp_flit(exp_flit), .exp_len(exp_len), .exp_port(exp_port), .sent(sent),
        .errors(errors), .received(received)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // router sits at (1,1), x corrected first.
    function automatic port_e xy_route(input int dx, input int dy);
        if (dx != 1)
            return (dx > 1) ? EAST : WEST;
        if (dy != 1)
            return (dy > 1) ? SOUTH : NORTH;
        return LOCAL;
    endfunction

    function automatic logic packets_open();
        foreach (pk_id[p, v])
            if (pk_id[p][v] >= 0)
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic start_packet(input int p, input int v);
        int    len;
        int    dx;
        int    dy;
        flit_t f;
        rng = xorshift32(rng);
        len = 1 + int'(rng % 32'd5);
        dx = int'(rng[9:8]);
        dy = int'(rng[11:10]);
        exp_len[sent] = len;
        exp_port[sent] = xy_route(dx, dy);
        for (int k = 0; k < len; k++)
        begin
            rng = xorshift32(rng);
            f.vc = 1'(v);
            f.data.word = rng[15:0];
            if (k == 0)
            begin
                f.kind = (len == 1) ? HEADTAIL : HEAD;
                f.data.head.dest_x = 2'(dx);
                f.data.head.dest_y = 2'(dy);
                f.data.head.tag = {3'(p), 9'(sent)};   // source port, packet number.
            end
            else
                f.kind = (k == len - 1) ? TAIL : BODY;
            exp_flit[sent][k] = f;
        end
        pk_id[p][v] = sent;
        pk_pos[p][v] = 0;
        sent++;
    endtask

    task automatic drive_inputs();
        int v;
        int id;
        for (int p = 0; p < PORT_NUM; p++)
        begin
            in_link[p] = '0;
            rng = xorshift32(rng);
            v = int'(rng[0]);
            if (pk_id[p][v] < 0 && sent < PACKETS && rng[1] && in_vc_free[p][v] && in_on_off[p][v])
                start_packet(p, v);
            if (pk_id[p][v] >= 0 && in_on_off[p][v])
            begin
                id = pk_id[p][v];
                in_link[p].valid = 1'b1;
                in_link[p].flit = exp_flit[id][pk_pos[p][v]];
                pk_pos[p][v]++;
                if (pk_pos[p][v] == exp_len[id])
                    pk_id[p][v] = -1;
            end
        end
    endtask

    initial
    begin
        forever #50 clk = ~clk;
    end

    // downstream buffers, random drain.
    always @(posedge clk)
    begin
        logic arrive;
        logic drain;
        for (int o = 0; o < PORT_NUM; o++)
        begin
            for (int w = 0; w < VC_NUM; w++)
            begin
                if (!rst_n)
                begin
                    ds_cnt[o][w] <= '0;
                    ds_open[o][w] <= 1'b0;
                end
                else
                begin
                    arrive = out_link[o].valid && out_link[o].flit.vc == 1'(w) &&
                             ds_cnt[o][w] != 4'(DS_DEPTH);
                    rng = xorshift32(rng);
                    drain = ds_cnt[o][w] != 0 && rng[0];
                    ds_cnt[o][w] <= ds_cnt[o][w] + 4'(arrive) - 4'(drain);
                    if (arrive && out_link[o].flit.kind == HEAD)
                        ds_open[o][w] <= 1'b1;
                    else if (arrive && out_link[o].flit.kind inside {TAIL, HEADTAIL})
                        ds_open[o][w] <= 1'b0;
                end
            end
        end
    end

    always @(negedge clk)
    begin
        for (int o = 0; o < PORT_NUM; o++)
        begin
            for (int w = 0; w < VC_NUM; w++)
            begin
                out_on_off[o][w] = (DS_DEPTH - int'(ds_cnt[o][w])) >= 3;
                out_vc_free[o][w] = ds_cnt[o][w] == 0 && !ds_open[o][w];
            end
        end
    end

    initial
    begin
        repeat (CYCLE_LIMIT) @(posedge clk);
        $display("watchdog expired with %0d of %0d packets received", received, PACKETS);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        foreach (pk_id[p, v])
            pk_id[p][v] = -1;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        while (sent < PACKETS || packets_open())
        begin
            @(negedge clk);
            drive_inputs();
        end
        @(negedge clk);
        in_link = '0;
        while (received < PACKETS)
            @(negedge clk);
        @(negedge clk);
        if (in_on_off !== '1 || in_vc_free !== '1)
        begin
            $display("router not idle after drain, on_off %b vc_free %b", in_on_off, in_vc_free);
            idle_errors++;
        end
        $display("errors: %0d, idle errors: %0d, packets received: %0d of %0d",
                 errors, idle_errors, received, PACKETS);
        if (errors == 0 && idle_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/router_checker.sv ====
`default_nettype none

module router_checker #(
    parameter int PACKETS = 200,
    parameter int MAX_LEN = 5,
    parameter int DS_DEPTH = 8
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  noc_params::link_t [noc_params::PORT_NUM-1:0] out_link,
    input  logic [3:0] ds_cnt [noc_params::PORT_NUM][noc_params::VC_NUM],
    input  logic       ds_open [noc_params::PORT_NUM][noc_params::VC_NUM],
    input  noc_params::flit_t exp_flit [PACKETS][MAX_LEN],
    input  int                exp_len [PACKETS],
    input  noc_params::port_e exp_port [PACKETS],
    input  int                sent,
    output int                errors,
    output int                received
);

    timeunit 1ns;
    timeprecision 1ns;

    import noc_params::*;

    int   err_count = 0;
    int   rx_count = 0;
    int   cur [PORT_NUM][VC_NUM];     // packet bound to each output vc.
    int   pos [PORT_NUM][VC_NUM];
    logic seen [PACKETS] = '{default: 1'b0};
    logic rst_q = 1'b0;

    assign errors = err_count;
    assign received = rx_count;

    always @(posedge clk)
    begin
        flit_t f;
        flit_t e;
        int    w;
        int    id;
        rst_q <= rst_n;
        for (int o = 0; o < PORT_NUM; o++)
        begin
            if (!rst_n)
            begin
                for (int k = 0; k < VC_NUM; k++)
                    cur[o][k] = -1;
            end
            if (out_link[o].valid && !rst_q)
            begin
                $display("** Error at %0t: out_link[%0d].valid expected 0 got 1", $time, o);
                err_count++;
            end
            else if (out_link[o].valid)
            begin
                f = out_link[o].flit;
                w = int'(f.vc);
                if (ds_cnt[o][w] == 4'(DS_DEPTH))
                begin
                    $display("** Error at %0t: flit sent to full buffer of output %0d vc %0d",
                             $time, o, w);
                    err_count++;
                end
                if (f.kind == HEAD || f.kind == HEADTAIL)
                begin
                    if (ds_open[o][w] || ds_cnt[o][w] != '0 || cur[o][w] >= 0)
                    begin
                        $display("** Error at %0t: head on output %0d vc %0d that is not free",
                                 $time, o, w);
                        err_count++;
                    end
                    id = int'(f.data.head.tag[8:0]);
                    if (id >= sent || seen[id])
                    begin
                        $display("** Error at %0t: unknown or repeated packet %0d on output %0d",
                                 $time, id, o);
                        err_count++;
                        cur[o][w] = -1;
                    end
                    else
                    begin
                        if (exp_port[id] != port_e'(o))
                        begin
                            $display(
                                "** Error at %0t: out_link port of packet %0d expected %0d got %0d",
                                $time, id, exp_port[id], o);
                            err_count++;
                        end
                        seen[id] = 1'b1;
                        cur[o][w] = id;
                        pos[o][w] = 0;
                    end
                end
                else if (cur[o][w] < 0)
                begin
                    $display(
                        "** Error at %0t: body or tail on output %0d vc %0d with no packet open",
                        $time, o, w);
                    err_count++;
                end
                if (cur[o][w] >= 0)
                begin
                    e = exp_flit[cur[o][w]][pos[o][w]];
                    e.vc = f.vc;                        // only the vc may change.
                    if (e !== f)
                    begin
                        $display("** Error at %0t: out_link[%0d].flit expected %h got %h",
                                 $time, o, e, f);
                        err_count++;
                    end
                    pos[o][w]++;
                    if (pos[o][w] == exp_len[cur[o][w]])
                    begin
                        rx_count++;
                        cur[o][w] = -1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/router.sv ====
`default_nettype none

module router #(
    parameter int BUFFER_SIZE = 8,
    parameter int X_CURRENT = 1,
    parameter int Y_CURRENT = 1
) (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  noc_params::link_t [noc_params::PORT_NUM-1:0]            in_link,
    output logic [noc_params::PORT_NUM-1:0][noc_params::VC_NUM-1:0] in_on_off,
    output logic [noc_params::PORT_NUM-1:0][noc_params::VC_NUM-1:0] in_vc_free,
    output noc_params::link_t [noc_params::PORT_NUM-1:0]            out_link,
    input  logic [noc_params::PORT_NUM-1:0][noc_params::VC_NUM-1:0] out_on_off,
    input  logic [noc_params::PORT_NUM-1:0][noc_params::VC_NUM-1:0] out_vc_free
);

    import noc_params::*;

    va_req_t [PORT_NUM-1:0][VC_NUM-1:0]   va_req;
    va_grant_t [PORT_NUM-1:0][VC_NUM-1:0] va_grant;
    vc_state_t [PORT_NUM-1:0][VC_NUM-1:0] vc_state;
    logic [PORT_NUM-1:0][VC_NUM-1:0]      pop;
    logic [PORT_NUM-1:0][VC_NUM-1:0]      vc_release;

    for (genvar p = 0; p < PORT_NUM; p++)
    begin : g_port
        input_port #(
            .BUFFER_SIZE(BUFFER_SIZE),
            .X_CURRENT(X_CURRENT),
            .Y_CURRENT(Y_CURRENT),
            .PORT_ID(p)
        ) i_input_port (
            .clk(clk),
            .rst_n(rst_n),
            .link(in_link[p]),
            .on_off(in_on_off[p]),
            .vc_free(in_vc_free[p]),
            .va_req(va_req[p]),
            .va_grant(va_grant[p]),
            .vc_state(vc_state[p]),
            .pop(pop[p])
        );
    end

    vc_allocator i_vc_allocator (
        .clk(clk),
        .rst_n(rst_n),
        .va_req(va_req),
        .out_vc_free(out_vc_free),
        .vc_release(vc_release),
        .va_grant(va_grant)
    );

    switch_stage i_switch_stage (
        .clk(clk),
        .rst_n(rst_n),
        .vc_state(vc_state),
        .out_on_off(out_on_off),
        .pop(pop),
        .vc_release(vc_release),
        .out_link(out_link)
    );

endmodule

`default_nettype wire

// ==== source/switch_stage.sv ====
`default_nettype none

module switch_stage (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  noc_params::vc_state_t
           [noc_params::PORT_NUM-1:0][noc_params::VC_NUM-1:0] vc_state,
    input  logic [noc_params::PORT_NUM-1:0][noc_params::VC_NUM-1:0] out_on_off,
    output logic [noc_params::PORT_NUM-1:0][noc_params::VC_NUM-1:0] pop,
    output logic [noc_params::PORT_NUM-1:0][noc_params::VC_NUM-1:0] vc_release,
    output noc_params::link_t [noc_params::PORT_NUM-1:0]           out_link
);

    import noc_params::*;

    localparam int VC_W = $clog2(VC_NUM);
    localparam int PORT_W = $clog2(PORT_NUM);

    logic [PORT_NUM-1:0][VC_W-1:0]   in_rr;
    logic [PORT_NUM-1:0][VC_W-1:0]   in_sel;
    logic [PORT_NUM-1:0]             in_req;
    logic [PORT_NUM-1:0]             in_won;
    logic [PORT_NUM-1:0][PORT_W-1:0] out_rr;
    logic [PORT_NUM-1:0][PORT_W-1:0] out_sel;
    logic [PORT_NUM-1:0]             out_hit;
    vc_state_t [PORT_NUM-1:0]        cand;      // vc put forward by each input.
    flit_t [PORT_NUM-1:0]            xbar_flit;
    logic [PORT_NUM-1:0][VC_NUM-1:0] release_d;
    logic [PORT_NUM-1:0]             link_valid_q;
    flit_t [PORT_NUM-1:0]            link_flit_q;

    // input side, one eligible vc per port.
    always_comb
    begin
        int v;
        for (int p = 0; p < PORT_NUM; p++)
        begin
            in_req[p] = 1'b0;
            in_sel[p] = in_rr[p];
            for (int k = 0; k < VC_NUM; k++)
            begin
                v = (int'(in_rr[p]) + k) % VC_NUM;
                if (!in_req[p] && vc_state[p][v].ready &&
                    out_on_off[vc_state[p][v].out_port][vc_state[p][v].out_vc])
                begin
                    in_req[p] = 1'b1;
                    in_sel[p] = VC_W'(v);
                end
            end
            cand[p] = vc_state[p][in_sel[p]];
        end
    end

    // output side, one input port per output.
    always_comb
    begin
        int p;
        out_hit = '0;
        out_sel = out_rr;
        in_won = '0;
        for (int o = 0; o < PORT_NUM; o++)
        begin
            for (int k = 0; k < PORT_NUM; k++)
            begin
                p = (int'(out_rr[o]) + k) % PORT_NUM;
                if (!out_hit[o] && in_req[p] && cand[p].out_port == port_e'(o))
                begin
                    out_hit[o] = 1'b1;
                    out_sel[o] = PORT_W'(p);
                end
            end
            if (out_hit[o])
                in_won[out_sel[o]] = 1'b1;
        end
    end

    always_comb
    begin
        pop = '0;
        release_d = '0;
        for (int p = 0; p < PORT_NUM; p++)
        begin
            if (in_won[p])
                pop[p][in_sel[p]] = 1'b1;
        end
        for (int o = 0; o < PORT_NUM; o++)
        begin
            xbar_flit[o] = cand[out_sel[o]].flit;
            xbar_flit[o].vc = cand[out_sel[o]].out_vc;     // downstream vc.
            if (out_hit[o] && (xbar_flit[o].kind == TAIL || xbar_flit[o].kind == HEADTAIL))
                release_d[o][xbar_flit[o].vc] = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            in_rr <= '0;
            out_rr <= '0;
            link_valid_q <= '0;
            vc_release <= '0;
        end
        else
        begin
            link_valid_q <= out_hit;
            vc_release <= release_d;    // lines up with the tail on the link.
            for (int p = 0; p < PORT_NUM; p++)
            begin
                if (in_won[p])
                    in_rr[p] <= VC_W'((int'(in_sel[p]) + 1) % VC_NUM);
            end
            for (int o = 0; o < PORT_NUM; o++)
            begin
                if (out_hit[o])
                    out_rr[o] <= PORT_W'((int'(out_sel[o]) + 1) % PORT_NUM);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int o = 0; o < PORT_NUM; o++)
        begin
            if (out_hit[o])
                link_flit_q[o] <= xbar_flit[o];
        end
    end

    always_comb
    begin
        for (int o = 0; o < PORT_NUM; o++)
        begin
            out_link[o].valid = link_valid_q[o];
            out_link[o].flit = link_flit_q[o];
        end
    end

endmodule

`default_nettype wire

// ==== source/vc_allocator.sv ====
`default_nettype none

module vc_allocator (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  noc_params::va_req_t
           [noc_params::PORT_NUM-1:0][noc_params::VC_NUM-1:0] va_req,
    input  logic [noc_params::PORT_NUM-1:0][noc_params::VC_NUM-1:0] out_vc_free,
    input  logic [noc_params::PORT_NUM-1:0][noc_params::VC_NUM-1:0] vc_release,
    output noc_params::va_grant_t
           [noc_params::PORT_NUM-1:0][noc_params::VC_NUM-1:0] va_grant
);

    import noc_params::*;

    localparam int VC_TOTAL = PORT_NUM * VC_NUM;
    localparam int PTR_W = $clog2(VC_TOTAL);

    logic [PORT_NUM-1:0][VC_NUM-1:0]     held;
    logic [PORT_NUM-1:0][VC_NUM-1:0]     take;
    logic [PORT_NUM-1:0][PTR_W-1:0]      rr_ptr;
    logic [PORT_NUM-1:0][PTR_W-1:0]      rr_next;
    logic [PORT_NUM-1:0]                 hit;
    va_grant_t [PORT_NUM-1:0][VC_NUM-1:0] grant_d;

    always_comb
    begin
        int   idx;
        int   win;
        logic found;
        logic vc_ok;
        logic vc_sel;
        grant_d = '0;
        take = '0;
        hit = '0;
        rr_next = rr_ptr;
        for (int o = 0; o < PORT_NUM; o++)
        begin
            vc_ok = 1'b0;
            vc_sel = 1'b0;
            for (int k = VC_NUM - 1; k >= 0; k--)
            begin
                if (!held[o][k] && out_vc_free[o][k])
                begin
                    vc_ok = 1'b1;
                    vc_sel = 1'(k);     // lowest free vc wins.
                end
            end
            found = 1'b0;
            win = 0;
            for (int k = 0; k < VC_TOTAL; k++)
            begin
                idx = (int'(rr_ptr[o]) + k) % VC_TOTAL;
                if (!found && va_req[idx / VC_NUM][idx % VC_NUM].valid &&
                    va_req[idx / VC_NUM][idx % VC_NUM].out_port == port_e'(o))
                begin
                    found = 1'b1;
                    win = idx;
                end
            end
            if (found && vc_ok)
            begin
                grant_d[win / VC_NUM][win % VC_NUM].valid = 1'b1;
                grant_d[win / VC_NUM][win % VC_NUM].out_vc = vc_sel;
                take[o][vc_sel] = 1'b1;
                hit[o] = 1'b1;
                rr_next[o] = PTR_W'((win + 1) % VC_TOTAL);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            va_grant <= '0;
            held <= '0;
            rr_ptr <= '0;
        end
        else
        begin
            va_grant <= grant_d;
            held <= (held & ~vc_release) | take;
            for (int o = 0; o < PORT_NUM; o++)
            begin
                if (hit[o])
                    rr_ptr[o] <= rr_next[o];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/input_port.sv ====
`default_nettype none

module input_port #(
    parameter int BUFFER_SIZE = 8,
    parameter int X_CURRENT = 1,
    parameter int Y_CURRENT = 1,
    parameter int PORT_ID = 0
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  noc_params::link_t                           link,
    output logic [noc_params::VC_NUM-1:0]               on_off,
    output logic [noc_params::VC_NUM-1:0]               vc_free,
    output noc_params::va_req_t [noc_params::VC_NUM-1:0]   va_req,
    input  noc_params::va_grant_t [noc_params::VC_NUM-1:0] va_grant,
    output noc_params::vc_state_t [noc_params::VC_NUM-1:0] vc_state,
    input  logic [noc_params::VC_NUM-1:0]               pop
);

    import noc_params::*;

    localparam int PTR_W = $clog2(BUFFER_SIZE);
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    typedef enum logic [1:0] { VC_IDLE, VC_WAIT, VC_ACTIVE } vc_phase_e;

    for (genvar v = 0; v < VC_NUM; v++)
    begin : g_vc
        flit_t            mem [BUFFER_SIZE];
        flit_t            head;
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W-1:0] wr_ptr;
        logic [CNT_W-1:0] count;
        vc_phase_e        phase;
        port_e            route;
        port_e            out_port_q;
        logic             out_vc_q;
        logic             push;
        logic             head_at_front;
        logic             tail_pop;
        logic             active;
        logic             granted;

        assign push = link.valid && (link.flit.vc == 1'(v));
        assign head = mem[rd_ptr];
        assign head_at_front = (count != '0) && (head.kind == HEAD || head.kind == HEADTAIL);
        assign tail_pop = pop[v] && (head.kind == TAIL || head.kind == HEADTAIL);
        assign active = (phase == VC_ACTIVE);
        assign granted = va_grant[v].valid;

        // xy order with x corrected first.
        always_comb
        begin
            if (int'(head.data.head.dest_x) > X_CURRENT)
                route = EAST;
            else if (int'(head.data.head.dest_x) < X_CURRENT)
                route = WEST;
            else if (int'(head.data.head.dest_y) > Y_CURRENT)
                route = SOUTH;
            else if (int'(head.data.head.dest_y) < Y_CURRENT)
                route = NORTH;
            else
                route = LOCAL;
        end

        // no new request while a grant is in flight.
        assign va_req[v].valid = head_at_front && !active && !granted;
        assign va_req[v].out_port = route;

        // a fresh grant may be used in the same cycle.
        assign vc_state[v].ready = (count != '0) && (active || granted);
        assign vc_state[v].out_port = active ? out_port_q : route;
        assign vc_state[v].out_vc = active ? out_vc_q : va_grant[v].out_vc;
        assign vc_state[v].flit = head;

        assign on_off[v] = (BUFFER_SIZE - int'(count)) >= 3;
        assign vc_free[v] = (count == '0) && (phase == VC_IDLE);

        always_ff @(posedge clk)
        begin
            if (push)
                mem[wr_ptr] <= link.flit;
        end

        always_ff @(posedge clk)
        begin
            if (!rst_n)
            begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count <= '0;
            end
            else
            begin
                if (push)
                    wr_ptr <= (wr_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
                if (pop[v])
                    rd_ptr <= (rd_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
                case ({push, pop[v]})
                    2'b10: count <= count + 1'b1;
                    2'b01: count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        always_ff @(posedge clk)
        begin
            if (!rst_n)
                phase <= VC_IDLE;
            else
            begin
                case (phase)
                    VC_IDLE, VC_WAIT:
                    begin
                        if (granted)
                            phase <= tail_pop ? VC_IDLE : VC_ACTIVE;  // headtail may leave at once.
                        else if (head_at_front)
                            phase <= VC_WAIT;
                        else
                            phase <= VC_IDLE;
                    end
                    VC_ACTIVE:
                    begin
                        if (tail_pop)
                            phase <= VC_IDLE;
                    end
                    default: phase <= VC_IDLE;
                endcase
            end
        end

        always_ff @(posedge clk)
        begin
            if (granted)
            begin
                out_port_q <= route;
                out_vc_q <= va_grant[v].out_vc;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/noc_params.sv ====
`default_nettype none

package noc_params;

    localparam int MESH_SIZE_X = 4;
    localparam int MESH_SIZE_Y = 4;

    localparam int PORT_NUM = 5;
    localparam int VC_NUM = 2;

    localparam int COORD_X_W = $clog2(MESH_SIZE_X);
    localparam int COORD_Y_W = $clog2(MESH_SIZE_Y);
    localparam int DATA_W = 16;
    localparam int TAG_W = DATA_W - COORD_X_W - COORD_Y_W;

    // order matters, the value is the index into every per-port array.
    typedef enum logic [2:0] { LOCAL, NORTH, SOUTH, WEST, EAST } port_e;

    typedef enum logic [1:0] { HEAD, BODY, TAIL, HEADTAIL } flit_kind_e;

    typedef struct packed {
        logic [COORD_X_W-1:0] dest_x;
        logic [COORD_Y_W-1:0] dest_y;
        logic [TAG_W-1:0]     tag;      // source port and sequence number.
    } head_view_t;

    // head flits carry routing info, body and tail flits carry payload.
    typedef union packed {
        head_view_t        head;
        logic [DATA_W-1:0] word;
    } flit_data_u;

    typedef struct packed {
        flit_kind_e kind;
        logic       vc;
        flit_data_u data;
    } flit_t;

    typedef struct packed {
        logic  valid;
        flit_t flit;
    } link_t;

    typedef struct packed {
        logic  valid;
        port_e out_port;
    } va_req_t;

    typedef struct packed {
        logic valid;
        logic out_vc;
    } va_grant_t;

    typedef struct packed {
        logic  ready;       // flit waiting and downstream vc owned.
        port_e out_port;
        logic  out_vc;
        flit_t flit;
    } vc_state_t;

endpackage

`default_nettype wire
